// ==== backing_mem.sv ====
// Word-addressed backing memory with a fixed access latency
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module backing_mem (
    input  wire               clk,
    input  wire               arst_n,
    input  wire               mem_start,
    input  wire mem_pkg::mem_op_e mem_op,
    input  wire [`WORD_W-1:0] mem_addr,
    input  wire [`WORD_W-1:0] mem_wdata,
    output logic              mem_done,
    output logic [`WORD_W-1:0] mem_rdata
);

    localparam int AW = $clog2(`MEM_WORDS);
    localparam int CW = $clog2(`MEM_LAT + 1);

    logic [`WORD_W-1:0] mem [`MEM_WORDS];
    mem_pkg::mem_op_e   op_q;
    logic               busy;
    logic [CW-1:0]      cnt;      // Cycles since mem_start
    logic [AW-1:0]      addr_q;   // Word index
    logic [`WORD_W-1:0] wdata_q;

    assign mem_done  = busy && (cnt == CW'(`MEM_LAT));
    assign mem_rdata = mem[addr_q];   // Valid in the done cycle

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            op_q    <= mem_pkg::MOP_IDLE;
            addr_q  <= '0;
            wdata_q <= '0;
            for (int i = 0; i < `MEM_WORDS; i++)
                mem[i] <= '0;
        end else if (mem_start) begin
            busy    <= 1'b1;
            cnt     <= CW'(1);
            op_q    <= mem_op;
            addr_q  <= mem_addr[AW:1];
            wdata_q <= mem_wdata;
        end else if (mem_done) begin
            busy <= 1'b0;
            cnt  <= '0;
            if (op_q == mem_pkg::MOP_WRITE)
                mem[addr_q] <= wdata_q;   // Write lands at done
        end else if (busy) begin
            cnt <= cnt + CW'(1);
        end
    end

    // Arbiter must wait for done before the next start
    a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n) mem_start |-> !busy)
        else $error("backing_mem: start while an access is busy");

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
// Processor-side types: major opcodes and fetch states
`default_nettype none

package cpu_pkg;

    // Major opcode in the top 5 bits of an instruction
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_JALR  = 5'b00111,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_ALU   = 5'b11011  // Register-register ALU group
    } opcode_e;

    typedef enum logic {
        FS_RUN,
        FS_HALTED  // Entered on a fetched HALT, left only by reset
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== dmem_port.sv ====
// Data access port: one outstanding read or write on the memory arbiter
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module dmem_port (
    input  wire               clk,
    input  wire               arst_n,
    input  wire               d_rd,
    input  wire               d_wr,
    input  wire [`WORD_W-1:0] d_addr,
    input  wire [`WORD_W-1:0] d_wdata,
    input  wire               dp_mdone,
    input  wire [`WORD_W-1:0] mem_rdata,
    output logic [`WORD_W-1:0] d_rdata,
    output logic              d_done,
    output logic              d_err,
    output logic              dp_mreq,
    output mem_pkg::mem_op_e  dp_mop,
    output logic [`WORD_W-1:0] dp_maddr,
    output logic [`WORD_W-1:0] dp_mwdata
);

    mem_pkg::mem_op_e   op_q;
    logic               busy;
    logic               strobe;   // Accepted access
    logic [`WORD_W-1:0] addr_q;
    logic [`WORD_W-1:0] wdata_q;

    assign strobe = (d_rd || d_wr) && !busy; // Ignored while busy

    assign dp_mreq   = busy;
    assign dp_mop    = busy ? op_q : mem_pkg::MOP_IDLE;
    assign dp_maddr  = addr_q;
    assign dp_mwdata = wdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            op_q   <= mem_pkg::MOP_IDLE;
            d_done <= 1'b0;
            d_err  <= 1'b0;
        end else begin
            d_done <= 1'b0;
            d_err  <= 1'b0;
            if (strobe) begin
                if (d_addr[0]) begin
                    d_done <= 1'b1;       // Misaligned, answered without memory
                    d_err  <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    op_q <= d_wr ? mem_pkg::MOP_WRITE : mem_pkg::MOP_READ;
                end
            end else if (busy && dp_mdone) begin
                busy   <= 1'b0;
                d_done <= 1'b1;           // One cycle after the arbiter's done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            addr_q  <= d_addr;
            wdata_q <= d_wdata;
        end
        if (busy && dp_mdone && op_q == mem_pkg::MOP_READ)
            d_rdata <= mem_rdata;
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n) !(d_rd && d_wr))
        else $error("dmem_port: read and write strobes together");

endmodule

`default_nettype wire

// ==== fetch.sv ====
// Fetch stage: PC register, branch select, PC+2, hold logic, HALT decode
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module fetch (
    input  wire               clk,
    input  wire               arst_n,
    input  wire               fetch_en,
    input  wire               branch,      // Take pc_b this cycle
    input  wire [`WORD_W-1:0] pc_b,        // Target from execute
    input  wire               nop,
    input  wire               nop_branch,
    input  wire [`WORD_W-1:0] ic_data,
    input  wire               ic_done,
    input  wire               ic_err,
    output logic [`WORD_W-1:0] ic_addr,
    output logic              ic_rd,
    output logic [`WORD_W-1:0] instr,
    output logic [`WORD_W-1:0] pc_curr,
    output logic [`WORD_W-1:0] pc_next,
    output logic              fetch_stall,
    output logic              halted,
    output logic              err
);

    cpu_pkg::fetch_state_e state;
    cpu_pkg::opcode_e      op;       // Major opcode of the returned word
    logic [`WORD_W-1:0]    pc_reg;
    logic [`WORD_W-1:0]    pc_sum;
    logic                  halt_hit; // HALT fetched this cycle
    logic                  hold;

    assign pc_curr = branch ? pc_b : pc_reg;
    assign ic_addr = pc_curr;
    assign ic_rd   = (state == cpu_pkg::FS_RUN) && fetch_en; // No reads once halted
    assign instr   = ic_data;
    assign err     = ic_err;
    assign halted  = (state == cpu_pkg::FS_HALTED);

    // Stalled until the cache has the word
    assign fetch_stall = !ic_done || !fetch_en;

    assign op       = cpu_pkg::opcode_e'(ic_data[`WORD_W-1 -: 5]);
    assign halt_hit = ic_rd && ic_done && (op == cpu_pkg::OP_HALT);

    // Sequential PC, frozen on a hold or on the HALT word itself
    assign pc_sum  = pc_curr + `WORD_W'(2);
    assign hold    = nop || nop_branch || fetch_stall || halted || halt_hit;
    assign pc_next = hold ? pc_curr : pc_sum;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_reg <= '0;
            state  <= cpu_pkg::FS_RUN;
        end else begin
            if (!ic_err)
                pc_reg <= pc_next;            // Odd target never lands in the PC
            if (halt_hit)
                state <= cpu_pkg::FS_HALTED;
        end
    end

    // Relies on the cache flagging every odd address as ic_err
    a_pc_even: assert property (@(posedge clk) disable iff (!arst_n) !pc_reg[0])
        else $error("fetch: PC register holds odd value %h", pc_reg);

endmodule

`default_nettype wire

// ==== fetch_mem_top.f ====
+incdir+.
cpu_pkg.sv
mem_pkg.sv
fetch.sv
icache.sv
dmem_port.sv
mem_arbiter.sv
backing_mem.sv
fetch_mem_top.sv
tb_fetch_mem_top.sv

// ==== fetch_mem_top.sv ====
// Top level: fetch stage, instruction cache, data port, arbiter, memory
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module fetch_mem_top (
    input  wire               clk,
    input  wire               arst_n,
    input  wire               fetch_en,
    input  wire               branch,
    input  wire [`WORD_W-1:0] pc_b,
    input  wire               nop,
    input  wire               nop_branch,
    input  wire               d_rd,
    input  wire               d_wr,
    input  wire [`WORD_W-1:0] d_addr,
    input  wire [`WORD_W-1:0] d_wdata,
    output logic [`WORD_W-1:0] instr,
    output logic [`WORD_W-1:0] pc_curr,
    output logic [`WORD_W-1:0] pc_next,
    output logic              fetch_stall,
    output logic              halted,
    output logic              err,
    output logic [`WORD_W-1:0] d_rdata,
    output logic              d_done,
    output logic              d_err
);

    // Fetch to cache
    logic [`WORD_W-1:0] ic_addr;
    logic [`WORD_W-1:0] ic_data;
    logic               ic_rd;
    logic               ic_done;
    logic               ic_err;
    // Requesters to arbiter
    logic               ic_mreq;
    logic               ic_mdone;
    logic [`WORD_W-1:0] ic_maddr;
    logic               dp_mreq;
    logic               dp_mdone;
    mem_pkg::mem_op_e   dp_mop;
    logic [`WORD_W-1:0] dp_maddr;
    logic [`WORD_W-1:0] dp_mwdata;
    // Arbiter to memory
    logic               mem_start;
    logic               mem_done;
    mem_pkg::mem_op_e   mem_op;
    logic [`WORD_W-1:0] mem_addr;
    logic [`WORD_W-1:0] mem_wdata;
    logic [`WORD_W-1:0] mem_rdata;   // Shared by both requesters

    fetch u_fetch (
        .clk(clk), .arst_n(arst_n), .fetch_en(fetch_en), .branch(branch),
        .pc_b(pc_b), .nop(nop), .nop_branch(nop_branch),
        .ic_data(ic_data), .ic_done(ic_done), .ic_err(ic_err),
        .ic_addr(ic_addr), .ic_rd(ic_rd), .instr(instr), .pc_curr(pc_curr),
        .pc_next(pc_next), .fetch_stall(fetch_stall), .halted(halted), .err(err)
    );

    icache u_icache (
        .clk(clk), .arst_n(arst_n), .ic_addr(ic_addr), .ic_rd(ic_rd),
        .ic_mdone(ic_mdone), .mem_rdata(mem_rdata), .ic_data(ic_data),
        .ic_done(ic_done), .ic_err(ic_err), .ic_mreq(ic_mreq), .ic_maddr(ic_maddr)
    );

    dmem_port u_dmem_port (
        .clk(clk), .arst_n(arst_n), .d_rd(d_rd), .d_wr(d_wr), .d_addr(d_addr),
        .d_wdata(d_wdata), .dp_mdone(dp_mdone), .mem_rdata(mem_rdata),
        .d_rdata(d_rdata), .d_done(d_done), .d_err(d_err), .dp_mreq(dp_mreq),
        .dp_mop(dp_mop), .dp_maddr(dp_maddr), .dp_mwdata(dp_mwdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk(clk), .arst_n(arst_n), .dp_mreq(dp_mreq), .dp_mop(dp_mop),
        .dp_maddr(dp_maddr), .dp_mwdata(dp_mwdata), .ic_mreq(ic_mreq),
        .ic_maddr(ic_maddr), .mem_done(mem_done), .dp_mdone(dp_mdone),
        .ic_mdone(ic_mdone), .mem_start(mem_start), .mem_op(mem_op),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    backing_mem u_backing_mem (
        .clk(clk), .arst_n(arst_n), .mem_start(mem_start), .mem_op(mem_op),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_done(mem_done),
        .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

// ==== icache.sv ====
// Direct-mapped instruction cache of single-word lines
// Refills one line per miss through the memory arbiter
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module icache (
    input  wire               clk,
    input  wire               arst_n,
    input  wire [`WORD_W-1:0] ic_addr,
    input  wire               ic_rd,
    input  wire               ic_mdone,   // Refill word is on mem_rdata
    input  wire [`WORD_W-1:0] mem_rdata,
    output logic [`WORD_W-1:0] ic_data,
    output logic              ic_done,
    output logic              ic_err,
    output logic              ic_mreq,
    output logic [`WORD_W-1:0] ic_maddr
);

    localparam int IDX_W = $clog2(`IC_LINES);
    localparam int TAG_W = `WORD_W - 1 - IDX_W; // Bit 0 is the byte offset

    mem_pkg::ic_state_e state;
    logic [`IC_LINES-1:0] valid;
    logic [TAG_W-1:0]     tag_mem  [`IC_LINES];
    logic [`WORD_W-1:0]   data_mem [`IC_LINES];
    logic [`WORD_W-1:0]   fill_addr;   // Address of the line being refilled
    logic [IDX_W-1:0]     idx;
    logic [IDX_W-1:0]     fill_idx;
    logic [TAG_W-1:0]     tag;
    logic                 hit;
    logic                 miss;
    logic                 fill_end;

    // Word address split into index and tag
    assign idx      = ic_addr[IDX_W:1];
    assign tag      = ic_addr[`WORD_W-1 -: TAG_W];
    assign fill_idx = fill_addr[IDX_W:1];

    assign hit  = valid[idx] && (tag_mem[idx] == tag);
    assign miss = (state == mem_pkg::IC_LOOKUP) && ic_rd && !ic_addr[0] && !hit;

    assign ic_err  = ic_addr[0];          // Misaligned and never refilled
    assign ic_done = (state == mem_pkg::IC_LOOKUP) && ic_rd && !ic_addr[0] && hit;
    assign ic_data = data_mem[idx];

    // Request held from IC_FILL through IC_WAIT
    assign ic_mreq  = (state != mem_pkg::IC_LOOKUP);
    assign ic_maddr = fill_addr;
    assign fill_end = ic_mreq && ic_mdone;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= mem_pkg::IC_LOOKUP;
            valid <= '0;                  // Cold cache
        end else begin
            case (state)
                mem_pkg::IC_LOOKUP: begin
                    if (miss)
                        state <= mem_pkg::IC_FILL;
                end
                mem_pkg::IC_FILL: begin
                    state <= fill_end ? mem_pkg::IC_LOOKUP : mem_pkg::IC_WAIT;
                end
                mem_pkg::IC_WAIT: begin
                    if (fill_end)
                        state <= mem_pkg::IC_LOOKUP; // Line hits on return
                end
                default: state <= mem_pkg::IC_LOOKUP;
            endcase
            if (fill_end)
                valid[fill_idx] <= 1'b1;
        end
    end

    // Tag and data arrays plus the captured miss address
    always_ff @(posedge clk) begin
        if (miss)
            fill_addr <= ic_addr;
        if (fill_end) begin
            tag_mem[fill_idx]  <= fill_addr[`WORD_W-1 -: TAG_W];
            data_mem[fill_idx] <= mem_rdata;
        end
    end

    // Arbiter done only for a refill that is still pending
    a_done_with_req: assert property (@(posedge clk) disable iff (!arst_n)
        ic_mdone |-> ic_mreq)
        else $error("icache: refill done without a pending request");

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
// Fixed-priority arbiter for the backing memory with the data port first
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module mem_arbiter (
    input  wire               clk,
    input  wire               arst_n,
    input  wire               dp_mreq,
    input  wire mem_pkg::mem_op_e dp_mop,
    input  wire [`WORD_W-1:0] dp_maddr,
    input  wire [`WORD_W-1:0] dp_mwdata,
    input  wire               ic_mreq,
    input  wire [`WORD_W-1:0] ic_maddr,
    input  wire               mem_done,
    output logic              dp_mdone,
    output logic              ic_mdone,
    output logic              mem_start,
    output mem_pkg::mem_op_e  mem_op,
    output logic [`WORD_W-1:0] mem_addr,
    output logic [`WORD_W-1:0] mem_wdata
);

    mem_pkg::grant_e owner;   // Holder of the access in flight
    mem_pkg::grant_e winner;  // Priority pick among new requests
    mem_pkg::grant_e sel;

    assign winner = dp_mreq ? mem_pkg::GNT_DATA :
                    ic_mreq ? mem_pkg::GNT_INSTR : mem_pkg::GNT_NONE;
    assign sel    = (owner == mem_pkg::GNT_NONE) ? winner : owner;

    // New access only when the memory is free
    assign mem_start = (owner == mem_pkg::GNT_NONE) && (winner != mem_pkg::GNT_NONE);

    always_comb begin
        case (sel)
            mem_pkg::GNT_DATA: begin
                mem_op    = dp_mop;
                mem_addr  = dp_maddr;
                mem_wdata = dp_mwdata;
            end
            mem_pkg::GNT_INSTR: begin
                mem_op    = mem_pkg::MOP_READ;   // Cache only reads
                mem_addr  = ic_maddr;
                mem_wdata = '0;
            end
            default: begin
                mem_op    = mem_pkg::MOP_IDLE;
                mem_addr  = '0;
                mem_wdata = '0;
            end
        endcase
    end

    // Done steered to the owner only
    assign dp_mdone = mem_done && (owner == mem_pkg::GNT_DATA);
    assign ic_mdone = mem_done && (owner == mem_pkg::GNT_INSTR);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            owner <= mem_pkg::GNT_NONE;
        else if (mem_start)
            owner <= winner;
        else if (mem_done)
            owner <= mem_pkg::GNT_NONE;   // Released and free next cycle
    end

    // Every memory done lands on exactly one requester
    a_one_done: assert property (@(posedge clk) disable iff (!arst_n)
        mem_done |-> (dp_mdone ^ ic_mdone))
        else $error("mem_arbiter: memory done reached no requester or both");

endmodule

`default_nettype wire

// ==== mem_params.svh ====
// Word width, memory depth, memory latency and cache size macros
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

`define WORD_W    16   // Data and address width
`define MEM_WORDS 256  // Backing memory depth in words
`define MEM_LAT   4    // Cycles from mem_start to mem_done

// Direct-mapped instruction cache, one word per line
`define IC_LINES  16

`endif

// ==== mem_pkg.sv ====
// Memory-side types: request opcodes, cache FSM states, arbiter owners
`default_nettype none

package mem_pkg;

    typedef enum logic [1:0] {
        MOP_IDLE,
        MOP_READ,
        MOP_WRITE
    } mem_op_e;

    // Instruction cache controller
    typedef enum logic [1:0] {
        IC_LOOKUP,  // Tag compare, hits served here
        IC_FILL,    // Refill request raised
        IC_WAIT     // Waiting for memory done
    } ic_state_e;

    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_DATA,
        GNT_INSTR
    } grant_e;

endpackage

`default_nettype wire

// ==== tb_fetch_mem_top.sv ====
// Testbench for fetch_mem_top with program load, fetch passes, branch and NOP,
// contention with the data port and a HALT freeze
`timescale 1ns/1ns
`default_nettype none
`include "mem_params.svh"

module tb_fetch_mem_top;

    localparam int          AW         = $clog2(`MEM_WORDS);
    localparam int          DONE_LIMIT = 64;     // Cycles allowed per data access
    localparam int          RUN_LIMIT  = 2000;   // Cycles allowed per fetch run
    localparam int          PROG_WORDS = 48;
    localparam int          HALT_IDX   = 47;     // HALT sits at byte address 94
    localparam int          DATA_BASE  = 128;    // Data region word index
    localparam int          DATA_WORDS = 8;
    localparam logic [15:0] LOOP_END   = 16'd22; // Fits in the 16 cache lines
    localparam logic [15:0] FAR_PC     = 16'd32;

    logic        clk;
    logic        arst_n;
    logic        fetch_en;
    logic        branch;
    logic [15:0] pc_b;
    logic        nop;
    logic        nop_branch;
    logic        d_rd;
    logic        d_wr;
    logic [15:0] d_addr;
    logic [15:0] d_wdata;
    logic [15:0] instr;
    logic [15:0] pc_curr;
    logic [15:0] pc_next;
    logic        fetch_stall;
    logic        halted;
    logic        err;
    logic [15:0] d_rdata;
    logic        d_done;
    logic        d_err;

    logic [15:0] sb [`MEM_WORDS];   // Mirror of every data port write
    logic [31:0] lfsr_state;
    logic        repeat_pass;       // Second pass over cached words
    logic        timed_out;
    string       test_name;
    int          errors;
    int          checks;
    int          tests;
    int          test_err_base;

    fetch_mem_top UUT (
        .clk(clk), .arst_n(arst_n), .fetch_en(fetch_en), .branch(branch), .pc_b(pc_b),
        .nop(nop), .nop_branch(nop_branch), .d_rd(d_rd), .d_wr(d_wr), .d_addr(d_addr),
        .d_wdata(d_wdata), .instr(instr), .pc_curr(pc_curr), .pc_next(pc_next),
        .fetch_stall(fetch_stall), .halted(halted), .err(err), .d_rdata(d_rdata),
        .d_done(d_done), .d_err(d_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps x^32 + x^22 + x^2 + x + 1 with one step per bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] program_word();
        logic [15:0] w;
        w = rand_bits(16);
        if (w[15:11] == cpu_pkg::OP_HALT)
            w[15:11] = cpu_pkg::OP_NOP;      // Keep HALT out of ordinary words
        return w;
    endfunction

    function automatic logic [15:0] word_at(input logic [15:0] addr);
        return sb[addr[AW:1]];
    endfunction

    function automatic logic [4:0] op_at(input logic [15:0] addr);
        logic [15:0] w;
        w = sb[addr[AW:1]];
        return w[15:11];
    endfunction

    task automatic check_eq(input string what, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
        tests++;
    endtask

    task automatic finish_test();
        $display("test %s finished with %0d errors", test_name, errors - test_err_base);
    endtask

    // Done may already be up at the negedge the strobe drops
    task automatic wait_data_done(input string what);
        int cnt;
        cnt = 0;
        while (!d_done && cnt < DONE_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!d_done) begin
            $display("Timeout: data port gave no done for %s in %0d cycles", what, DONE_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
        @(negedge clk);
        d_wr    = 1'b1;
        d_addr  = addr;
        d_wdata = data;
        @(negedge clk);
        d_wr = 1'b0;
        wait_data_done("write");
        if (!timed_out && !addr[0])
            sb[addr[AW:1]] = data;
    endtask

    task automatic read_word(input logic [15:0] addr, output logic [15:0] data,
                             output logic bad);
        @(negedge clk);
        d_rd   = 1'b1;
        d_addr = addr;
        @(negedge clk);
        d_rd = 1'b0;
        wait_data_done("read");
        data = d_rdata;
        bad  = d_err;
    endtask

    task automatic run_to_pc(input logic [15:0] target);
        int cnt;
        cnt = 0;
        while (pc_curr != target && cnt < RUN_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (pc_curr != target) begin
            $display("Timeout: fetch did not reach pc %h in %0d cycles", target, RUN_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic load_program();
        logic [15:0] rd;
        logic        bad;
        start_test("load_readback");
        for (int i = 0; i < PROG_WORDS; i++)
            write_word(16'(2 * i), (i == HALT_IDX) ?
                       {cpu_pkg::OP_HALT, 11'(rand_bits(11))} : program_word());
        for (int i = 0; i < DATA_WORDS && !timed_out; i++)
            write_word(16'(2 * (DATA_BASE + i)), program_word());
        for (int i = 0; i < 4 && !timed_out; i++) begin
            read_word(16'(2 * (DATA_BASE + i)), rd, bad);
            check_eq("readback", word_at(16'(2 * (DATA_BASE + i))), rd);
            read_word(16'(2 * i), rd, bad);
            check_eq("program readback", word_at(16'(2 * i)), rd);
        end
        if (!timed_out) begin
            read_word(16'(2 * DATA_BASE + 1), rd, bad);
            check_eq("d_err on odd address", 16'd1, 16'(bad));
        end
        finish_test();
    endtask

    task automatic fetch_under_contention();
        logic [15:0] rd;
        logic        bad;
        start_test("contention");
        for (int i = 0; i < 6 && !timed_out; i++) begin
            read_word(16'(2 * (DATA_BASE + i)), rd, bad);
            check_eq("read during misses", word_at(16'(2 * (DATA_BASE + i))), rd);
            repeat (rand_bits(2)) @(negedge clk);    // Vary the overlap with refills
        end
        finish_test();
    endtask

    // Instruction word and PC rules sampled on the rising edge
    a_instr_match: assert property (@(posedge clk) disable iff (!arst_n)
        (fetch_en && !fetch_stall) |-> (instr == word_at(pc_curr)))
        else begin
            errors++;
            $display("CHECK FAILED %s: instr expected %h, actual %h", test_name,
                     word_at($sampled(pc_curr)), $sampled(instr));
        end

    a_pc_step: assert property (@(posedge clk) disable iff (!arst_n)
        (fetch_en && !fetch_stall && !nop && !nop_branch && op_at(pc_curr) != cpu_pkg::OP_HALT)
        |-> (pc_next == pc_curr + 16'd2))
        else begin
            errors++;
            $display("CHECK FAILED %s: pc_next expected %h, actual %h", test_name,
                     $sampled(pc_curr) + 16'd2, $sampled(pc_next));
        end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (fetch_stall || nop || nop_branch) |-> (pc_next == pc_curr))
        else begin
            errors++;
            $display("CHECK FAILED %s: held pc_next expected %h, actual %h", test_name,
                     $sampled(pc_curr), $sampled(pc_next));
        end

    a_branch_sel: assert property (@(posedge clk) disable iff (!arst_n)
        branch |-> (pc_curr == pc_b))
        else begin
            errors++;
            $display("CHECK FAILED %s: pc_curr expected %h, actual %h", test_name,
                     $sampled(pc_b), $sampled(pc_curr));
        end

    a_hit_on_repeat: assert property (@(posedge clk) disable iff (!arst_n)
        (repeat_pass && fetch_en) |-> !fetch_stall)
        else begin
            errors++;
            $display("CHECK FAILED %s: fetch_stall expected 0, actual 1", test_name);
        end

    a_halt_on_fetch: assert property (@(posedge clk) disable iff (!arst_n)
        (fetch_en && !fetch_stall && op_at(pc_curr) == cpu_pkg::OP_HALT) |=> halted)
        else begin
            errors++;
            $display("CHECK FAILED %s: halted expected 1, actual 0", test_name);
        end

    a_halt_freeze: assert property (@(posedge clk) disable iff (!arst_n)
        (halted && !branch) |=> (branch || pc_curr == $past(pc_curr)))
        else begin
            errors++;
            $display("CHECK FAILED %s: frozen pc expected %h, actual %h", test_name,
                     $past(pc_curr), $sampled(pc_curr));
        end

    a_odd_err: assert property (@(posedge clk) disable iff (!arst_n)
        (branch && pc_b[0]) |-> err)
        else begin
            errors++;
            $display("CHECK FAILED %s: err expected 1, actual 0", test_name);
        end

    initial begin
        lfsr_state  = 32'h149c9b70;
        arst_n      = 1'b0;
        fetch_en    = 1'b0;
        branch      = 1'b0;
        pc_b        = '0;
        nop         = 1'b0;
        nop_branch  = 1'b0;
        d_rd        = 1'b0;
        d_wr        = 1'b0;
        d_addr      = '0;
        d_wdata     = '0;
        repeat_pass = 1'b0;
        timed_out   = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        for (int i = 0; i < `MEM_WORDS; i++)
            sb[i] = '0;                      // Memory clears on reset
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("reset");
        check_eq("fetch_stall", 16'd1, 16'(fetch_stall));
        check_eq("halted", 16'd0, 16'(halted));
        check_eq("err", 16'd0, 16'(err));
        check_eq("pc_curr", 16'd0, pc_curr);
        check_eq("d_done", 16'd0, 16'(d_done));
        finish_test();

        load_program();

        if (!timed_out) begin
            start_test("seq_fetch");
            @(negedge clk);
            fetch_en = 1'b1;
            run_to_pc(LOOP_END);
            finish_test();
        end
        if (!timed_out) begin
            start_test("cache_hit");
            branch      = 1'b1;              // Back to the start where all lines are warm
            pc_b        = 16'd0;
            repeat_pass = 1'b1;
            @(negedge clk);
            branch = 1'b0;
            run_to_pc(LOOP_END);
            repeat_pass = 1'b0;
            finish_test();
        end
        if (!timed_out) begin
            start_test("branch_nop");
            branch = 1'b1;                   // Warm line so nop and nop_branch meet a hit
            pc_b   = 16'd0;
            @(negedge clk);
            branch = 1'b0;
            nop    = 1'b1;
            @(negedge clk);
            nop        = 1'b0;
            nop_branch = 1'b1;
            @(negedge clk);
            nop_branch = 1'b0;
            branch     = 1'b1;
            pc_b       = FAR_PC;             // Cold line with the target held through the miss
            @(negedge clk);
            branch = 1'b0;
            check_eq("pc after branch", FAR_PC, pc_curr);
            finish_test();
        end
        if (!timed_out)
            fetch_under_contention();
        if (!timed_out) begin
            int halt_cnt;
            start_test("halt");
            halt_cnt = 0;
            while (!halted && halt_cnt < RUN_LIMIT) begin
                @(negedge clk);
                halt_cnt++;
            end
            if (!halted) begin
                $display("Timeout: fetch never reached the HALT word");
                timed_out = 1'b1;
            end
            check_eq("halted pc", 16'(2 * HALT_IDX), pc_curr);
            repeat (4) @(negedge clk);
            branch = 1'b1;
            pc_b   = 16'd41;                 // Odd target
            @(negedge clk);
            check_eq("err on odd pc_b", 16'd1, 16'(err));
            branch = 1'b0;
            @(negedge clk);
            check_eq("pc after odd branch", 16'(2 * HALT_IDX), pc_curr);
            finish_test();
        end

        $display("tests: %0d, checks: %0d, errors: %0d, timeout: %0d", tests, checks, errors,
                 timed_out);
        if (errors == 0 && !timed_out)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
